//--- logic/board_pkg.sv
/*
 shared definitions for the board shell
 data widths and their typedefs, register map,
 reset hold count and H-bridge control fields
*/
`default_nettype none

package board_pkg;

	// register port widths
	typedef logic [3:0]  addr_t;
	typedef logic [15:0] word_t;

	// one bit per GPIO pad
	typedef logic [15:0] gpio_t;

	// PWM duty and period counter share a width
	typedef logic [7:0]  duty_t;

	// two pins per bridge channel
	typedef logic [7:0]  hbr_pins_t;

	// cycles counted after external reset release
	// small for simulation, hardware would count much longer
	localparam logic [15:0] RESET_HOLD_COUNT = 16'd64;

	localparam int HBR_CHANNELS = 4;

	// control register fields
	localparam int HBR_CTRL_EN_BIT  = 0;
	localparam int HBR_CTRL_DIR_LSB = 4;

	// register map
	localparam addr_t REG_GPIO_OUT  = 4'd0;
	localparam addr_t REG_GPIO_DIR  = 4'd1;
	// read only
	localparam addr_t REG_GPIO_IN   = 4'd2;
	localparam addr_t REG_HBR_CTRL  = 4'd3;
	localparam addr_t REG_HBR_DUTY0 = 4'd4;
	localparam addr_t REG_HBR_DUTY1 = 4'd5;
	localparam addr_t REG_HBR_DUTY2 = 4'd6;
	localparam addr_t REG_HBR_DUTY3 = 4'd7;

endpackage

`default_nettype wire

//--- logic/reset_sanity.sv
/*
 reset_sanity
 post-reset hold counter, keeps the internal
 reset asserted until the count has run out
*/
`timescale 1ns/10ps
`default_nettype none

module reset_sanity
(
	input  logic clock_50mhz,
	input  logic reset2a,
	output logic core_reset_o
);

	import board_pkg::*;

	// saturating hold counter
	logic [15:0] hold_cnt;
	logic        hold_done;

	// counter has reached the hold value
	assign hold_done = (hold_cnt == RESET_HOLD_COUNT);

	always_ff @(posedge clock_50mhz)
	begin
		// registered copy of the count state
		core_reset_o <= !hold_done;

		if (reset2a)
		begin
			// restart on every edge the external reset is seen
			hold_cnt     <= '0;
			core_reset_o <= 1'b1;
		end
		else
		begin
			// count up, then stick at the hold value
			if (!hold_done)
			begin
				hold_cnt <= hold_cnt + 16'd1;
			end
		end
	end

	// a glitch on reset2a restarts the whole count,
	// so short pulses still give a full-length internal reset
	// core_reset_o falls RESET_HOLD_COUNT+1 edges after release

endmodule

`default_nettype wire

//--- logic/mmio_decode.sv
/*
 mmio_decode
 register port address decode, per-group write strobes,
 registered read mux and one-cycle read-valid pulse
*/
`timescale 1ns/10ps
`default_nettype none

module mmio_decode
(
	input  logic              clock_50mhz,
	input  logic              reset2a,
	input  logic              core_reset_i,
	input  logic              mmio_wr_i,
	input  logic              mmio_rd_i,
	input  board_pkg::addr_t  mmio_addr_i,
	input  board_pkg::word_t  mmio_wdata_i,
	output board_pkg::word_t  mmio_rdata_o,
	output logic              mmio_rvalid_o,
	output logic              gpio_out_wr_o,
	output logic              gpio_dir_wr_o,
	output logic              hbr_ctrl_wr_o,
	output logic              hbr_duty_wr_o,
	output logic [1:0]        hbr_duty_sel_o,
	output board_pkg::word_t  wdata_o,
	input  board_pkg::gpio_t  gpio_out_i,
	input  board_pkg::gpio_t  gpio_dir_i,
	input  board_pkg::gpio_t  gpio_in_i,
	input  board_pkg::word_t  hbr_ctrl_i,
	input  board_pkg::duty_t  hbr_duty0_i,
	input  board_pkg::duty_t  hbr_duty1_i,
	input  board_pkg::duty_t  hbr_duty2_i,
	input  board_pkg::duty_t  hbr_duty3_i
);

	import board_pkg::*;

	logic  wr_ok;
	logic  rd_ok;
	logic  duty_hit;
	addr_t duty_off;
	word_t rd_mux;

	// strobes are dropped while the core is held in reset
	assign wr_ok = mmio_wr_i && !core_reset_i;
	assign rd_ok = mmio_rd_i && !core_reset_i;

	// duty registers sit in one aligned block
	assign duty_hit = (mmio_addr_i >= REG_HBR_DUTY0) && (mmio_addr_i <= REG_HBR_DUTY3);
	assign duty_off = mmio_addr_i - REG_HBR_DUTY0;

	// write strobes, same edge as the sampled write
	assign gpio_out_wr_o  = wr_ok && (mmio_addr_i == REG_GPIO_OUT);
	assign gpio_dir_wr_o  = wr_ok && (mmio_addr_i == REG_GPIO_DIR);
	assign hbr_ctrl_wr_o  = wr_ok && (mmio_addr_i == REG_HBR_CTRL);
	assign hbr_duty_wr_o  = wr_ok && duty_hit;
	assign hbr_duty_sel_o = duty_off[1:0];
	// one shared data bus to every block
	assign wdata_o        = mmio_wdata_i;

	// read select, 8-bit values zero extended
	always_comb
	begin
		case (mmio_addr_i)
			REG_GPIO_OUT:  rd_mux = word_t'(gpio_out_i);
			REG_GPIO_DIR:  rd_mux = word_t'(gpio_dir_i);
			REG_GPIO_IN:   rd_mux = word_t'(gpio_in_i);
			REG_HBR_CTRL:  rd_mux = hbr_ctrl_i;
			REG_HBR_DUTY0: rd_mux = word_t'(hbr_duty0_i);
			REG_HBR_DUTY1: rd_mux = word_t'(hbr_duty1_i);
			REG_HBR_DUTY2: rd_mux = word_t'(hbr_duty2_i);
			REG_HBR_DUTY3: rd_mux = word_t'(hbr_duty3_i);
			// unmapped reads give zero
			default:       rd_mux = '0;
		endcase
	end

	// read data captured on the request edge
	always_ff @(posedge clock_50mhz)
	begin
		if (rd_ok)
		begin
			mmio_rdata_o <= rd_mux;
		end
	end

	// valid pulse one cycle after the sampled read
	always_ff @(posedge clock_50mhz)
	begin
		if (reset2a)
			mmio_rvalid_o <= 1'b0;
		else
			mmio_rvalid_o <= rd_ok;
	end

endmodule

`default_nettype wire

//--- logic/gpio_port.sv
/*
 gpio_port
 output and direction registers for 16 pads,
 two-flop input synchronizer for readback
*/
`timescale 1ns/10ps
`default_nettype none

module gpio_port
(
	input  logic              clock_50mhz,
	input  logic              core_reset_i,
	input  logic              out_wr_i,
	input  logic              dir_wr_i,
	input  board_pkg::word_t  wdata_i,
	input  board_pkg::gpio_t  pin_i,
	output board_pkg::gpio_t  pin_o,
	output board_pkg::gpio_t  oe_o,
	output board_pkg::gpio_t  out_o,
	output board_pkg::gpio_t  dir_o,
	output board_pkg::gpio_t  in_o
);

	import board_pkg::*;

	gpio_t out_q;
	gpio_t dir_q;

	// synchronizer stages
	gpio_t in_meta;
	gpio_t in_sync;

	// output value register
	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
		begin
			out_q <= '0;
		end
		else if (out_wr_i)
		begin
			out_q <= gpio_t'(wdata_i);
		end
	end

	// direction register, 1 drives the pad
	// all pads come up as inputs
	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
		begin
			dir_q <= '0;
		end
		else if (dir_wr_i)
		begin
			dir_q <= gpio_t'(wdata_i);
		end
	end

	// pad inputs are asynchronous to the core clock
	// first stage may go metastable, second one settles it
	always_ff @(posedge clock_50mhz)
	begin
		in_meta <= pin_i;
		in_sync <= in_meta;
	end

	// pad side
	// the pad buffer is resolved outside, direction acts as enable
	assign pin_o = out_q;
	assign oe_o  = dir_q;

	// register readback side
	assign out_o = out_q;
	assign dir_o = dir_q;
	// driven pins read back their own level through the pad
	assign in_o  = in_sync;

endmodule

`default_nettype wire

//--- logic/hbr_pwm.sv
/*
 hbr_pwm
 four-channel H-bridge PWM with a shared period counter,
 control and duty registers, registered pin drive
*/
`timescale 1ns/10ps
`default_nettype none

module hbr_pwm
(
	input  logic                  clock_50mhz,
	input  logic                  core_reset_i,
	input  logic                  ctrl_wr_i,
	input  logic                  duty_wr_i,
	input  logic [1:0]            duty_sel_i,
	input  board_pkg::word_t      wdata_i,
	output board_pkg::word_t      ctrl_o,
	output board_pkg::duty_t      duty0_o,
	output board_pkg::duty_t      duty1_o,
	output board_pkg::duty_t      duty2_o,
	output board_pkg::duty_t      duty3_o,
	output board_pkg::hbr_pins_t  pins_o
);

	import board_pkg::*;

	// 8-bit control, enable in bit 0, directions in bits 4..7
	logic [7:0]              ctrl_q;
	duty_t                   duty_q [HBR_CHANNELS];
	duty_t                   pwm_cnt;
	logic                    hbr_en;
	logic [HBR_CHANNELS-1:0] hbr_dir;
	hbr_pins_t               pins_d;

	assign hbr_en  = ctrl_q[HBR_CTRL_EN_BIT];
	assign hbr_dir = ctrl_q[HBR_CTRL_DIR_LSB +: HBR_CHANNELS];

	// control and duty registers, only the low byte is kept
	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
		begin
			ctrl_q <= '0;
			for (int k = 0; k < HBR_CHANNELS; k++)
			begin
				duty_q[k] <= '0;
			end
		end
		else
		begin
			if (ctrl_wr_i)
				ctrl_q <= wdata_i[7:0];
			if (duty_wr_i)
				duty_q[duty_sel_i] <= wdata_i[7:0];
		end
	end

	// free-running period counter, wraps 255 -> 0
	// one period is 256 cycles for every channel
	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
			pwm_cnt <= '0;
		else
			pwm_cnt <= pwm_cnt + 8'd1;
	end

	// pulse while counter below duty
	// direction bit picks which side of the pair carries it
	// the other side stays low so the bridge never shorts
	always_comb
	begin
		pins_d = '0;
		for (int k = 0; k < HBR_CHANNELS; k++)
		begin
			if (hbr_en && (pwm_cnt < duty_q[k]))
			begin
				if (hbr_dir[k])
					pins_d[2*k + 1] = 1'b1;
				else
					pins_d[2*k] = 1'b1;
			end
		end
	end

	// registered drive, no compare glitches at the pins
	always_ff @(posedge clock_50mhz)
	begin
		if (core_reset_i)
			pins_o <= '0;
		else
			pins_o <= pins_d;
	end

	// readback
	assign ctrl_o  = word_t'(ctrl_q);
	assign duty0_o = duty_q[0];
	assign duty1_o = duty_q[1];
	assign duty2_o = duty_q[2];
	assign duty3_o = duty_q[3];

endmodule

`default_nettype wire

//--- logic/board_top.sv
/*
 board_top
 board shell, connects reset hold, register
 decode, GPIO port and H-bridge PWM
*/
`timescale 1ns/10ps
`default_nettype none

module board_top
(
	input  logic                  clock_50mhz,
	input  logic                  reset2a,
	input  logic                  mmio_wr_i,
	input  logic                  mmio_rd_i,
	input  board_pkg::addr_t      mmio_addr_i,
	input  board_pkg::word_t      mmio_wdata_i,
	output board_pkg::word_t      mmio_rdata_o,
	output logic                  mmio_rvalid_o,
	input  board_pkg::gpio_t      gpio_pin_i,
	output board_pkg::gpio_t      gpio_pin_o,
	output board_pkg::gpio_t      gpio_oe_o,
	output board_pkg::hbr_pins_t  hbr_pins_o,
	output logic                  core_reset_o
);

	import board_pkg::*;

	// internal reset for every block
	logic       core_reset;

	// write strobes and shared data
	logic       gpio_out_wr;
	logic       gpio_dir_wr;
	logic       hbr_ctrl_wr;
	logic       hbr_duty_wr;
	logic [1:0] hbr_duty_sel;
	word_t      wdata;

	// register values back to the read mux
	gpio_t      gpio_out;
	gpio_t      gpio_dir;
	gpio_t      gpio_in;
	word_t      hbr_ctrl;
	duty_t      hbr_duty0;
	duty_t      hbr_duty1;
	duty_t      hbr_duty2;
	duty_t      hbr_duty3;

	reset_sanity u_reset_sanity
	(
		.clock_50mhz  (clock_50mhz),
		.reset2a      (reset2a),
		.core_reset_o (core_reset)
	);

	mmio_decode u_mmio_decode
	(
		.clock_50mhz    (clock_50mhz),
		.reset2a        (reset2a),
		.core_reset_i   (core_reset),
		.mmio_wr_i      (mmio_wr_i),
		.mmio_rd_i      (mmio_rd_i),
		.mmio_addr_i    (mmio_addr_i),
		.mmio_wdata_i   (mmio_wdata_i),
		.mmio_rdata_o   (mmio_rdata_o),
		.mmio_rvalid_o  (mmio_rvalid_o),
		.gpio_out_wr_o  (gpio_out_wr),
		.gpio_dir_wr_o  (gpio_dir_wr),
		.hbr_ctrl_wr_o  (hbr_ctrl_wr),
		.hbr_duty_wr_o  (hbr_duty_wr),
		.hbr_duty_sel_o (hbr_duty_sel),
		.wdata_o        (wdata),
		.gpio_out_i     (gpio_out),
		.gpio_dir_i     (gpio_dir),
		.gpio_in_i      (gpio_in),
		.hbr_ctrl_i     (hbr_ctrl),
		.hbr_duty0_i    (hbr_duty0),
		.hbr_duty1_i    (hbr_duty1),
		.hbr_duty2_i    (hbr_duty2),
		.hbr_duty3_i    (hbr_duty3)
	);

	// pads stay split into in, out and enable
	gpio_port u_gpio_port
	(
		.clock_50mhz  (clock_50mhz),
		.core_reset_i (core_reset),
		.out_wr_i     (gpio_out_wr),
		.dir_wr_i     (gpio_dir_wr),
		.wdata_i      (wdata),
		.pin_i        (gpio_pin_i),
		.pin_o        (gpio_pin_o),
		.oe_o         (gpio_oe_o),
		.out_o        (gpio_out),
		.dir_o        (gpio_dir),
		.in_o         (gpio_in)
	);

	hbr_pwm u_hbr_pwm
	(
		.clock_50mhz  (clock_50mhz),
		.core_reset_i (core_reset),
		.ctrl_wr_i    (hbr_ctrl_wr),
		.duty_wr_i    (hbr_duty_wr),
		.duty_sel_i   (hbr_duty_sel),
		.wdata_i      (wdata),
		.ctrl_o       (hbr_ctrl),
		.duty0_o      (hbr_duty0),
		.duty1_o      (hbr_duty1),
		.duty2_o      (hbr_duty2),
		.duty3_o      (hbr_duty3),
		.pins_o       (hbr_pins_o)
	);

	// internal reset visible at the board edge
	assign core_reset_o = core_reset;

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
/*
 testbench clock and reset source
 20 ns clock, reset held for two rising edges
*/
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
(
	output logic clock_50mhz,
	output logic reset2a
);

	// 50 MHz, toggle every 10 ns
	initial
	begin
		clock_50mhz = 1'b0;
		forever #10 clock_50mhz = ~clock_50mhz;
	end

	// reset released on the second rising edge
	initial
	begin
		reset2a = 1'b1;
		repeat (2) @(posedge clock_50mhz);
		reset2a <= 1'b0;
	end

endmodule

`default_nettype wire

//--- verif/board_props.sv
/*
 concurrent assertions for board_top
 read-valid timing, reset hold, bridge pair
 exclusion and GPIO output enable
*/
`timescale 1ns/10ps
`default_nettype none

module board_props
(
	input logic                  clock_50mhz,
	input logic                  reset2a,
	input logic                  mmio_wr_i,
	input logic                  mmio_rd_i,
	input board_pkg::addr_t      mmio_addr_i,
	input board_pkg::word_t      mmio_wdata_i,
	input logic                  mmio_rvalid_i,
	input logic                  core_reset_i,
	input board_pkg::gpio_t      gpio_oe_i,
	input board_pkg::hbr_pins_t  hbr_pins_i
);

	import board_pkg::*;

	// read accepted by the decoder
	logic rd_taken;
	// direction register write accepted by the decoder
	logic dir_wr_taken;

	assign rd_taken     = mmio_rd_i && !core_reset_i;
	assign dir_wr_taken = mmio_wr_i && !core_reset_i && (mmio_addr_i == REG_GPIO_DIR);

	// valid exactly one cycle after an accepted read
	rvalid_after_read: assert property (@(posedge clock_50mhz) disable iff (reset2a)
		rd_taken |=> mmio_rvalid_i)
		else $error("read valid missing one cycle after an accepted read");

	// and never without one
	rvalid_only_after_read: assert property (@(posedge clock_50mhz) disable iff (reset2a)
		!rd_taken |=> !mmio_rvalid_i)
		else $error("read valid without an accepted read");

	// external reset keeps the core in reset
	reset_held: assert property (@(posedge clock_50mhz)
		reset2a |=> core_reset_i)
		else $error("core reset low while external reset is high");

	// even pin and odd pin of a pair never high together
	pair_exclusive: assert property (@(posedge clock_50mhz)
		((hbr_pins_i & (hbr_pins_i >> 1)) & 8'h55) == 8'h00)
		else $error("both pins of an H-bridge pair driven high");

	// pad enable takes the value written to the direction register
	oe_follows_dir_write: assert property (@(posedge clock_50mhz) disable iff (reset2a)
		dir_wr_taken |=> (gpio_oe_i == $past(gpio_t'(mmio_wdata_i))))
		else $error("gpio output enable differs from the written direction");

	// and keeps it until the next write or core reset
	oe_held: assert property (@(posedge clock_50mhz) disable iff (reset2a)
		(!dir_wr_taken && !core_reset_i) |=> $stable(gpio_oe_i))
		else $error("gpio output enable changed without a direction write");

endmodule

bind board_top board_props props0
(
	.clock_50mhz   (clock_50mhz),
	.reset2a       (reset2a),
	.mmio_wr_i     (mmio_wr_i),
	.mmio_rd_i     (mmio_rd_i),
	.mmio_addr_i   (mmio_addr_i),
	.mmio_wdata_i  (mmio_wdata_i),
	.mmio_rvalid_i (mmio_rvalid_o),
	.core_reset_i  (core_reset),
	.gpio_oe_i     (gpio_oe_o),
	.hbr_pins_i    (hbr_pins_o)
);

`default_nettype wire

//--- verif/tb_board.sv
/*
 board_top testbench
 GPIO pad model, register port tasks, compare tasks,
 directed tests for reset hold, registers, GPIO and PWM
*/
`timescale 1ns/10ps
`default_nettype none

module tb_board;

	import board_pkg::*;

	logic      clock_50mhz;
	logic      reset2a;
	logic      mmio_wr;
	logic      mmio_rd;
	addr_t     mmio_addr;
	word_t     mmio_wdata;
	word_t     mmio_rdata;
	logic      mmio_rvalid;
	logic      core_reset;
	hbr_pins_t hbr_pins;

	// pad side of the GPIO block
	gpio_t     pad_in;
	gpio_t     pad_out;
	gpio_t     pad_oe;
	// level forced onto undriven pins from outside
	gpio_t     ext_val;

	tb_clock_gen clk0
	(
		.clock_50mhz (clock_50mhz),
		.reset2a     (reset2a)
	);

	// resolved pads, driven pins win over the outside level
	assign pad_in = (pad_oe & pad_out) | (~pad_oe & ext_val);

	board_top dut0
	(
		.clock_50mhz   (clock_50mhz),
		.reset2a       (reset2a),
		.mmio_wr_i     (mmio_wr),
		.mmio_rd_i     (mmio_rd),
		.mmio_addr_i   (mmio_addr),
		.mmio_wdata_i  (mmio_wdata),
		.mmio_rdata_o  (mmio_rdata),
		.mmio_rvalid_o (mmio_rvalid),
		.gpio_pin_i    (pad_in),
		.gpio_pin_o    (pad_out),
		.gpio_oe_o     (pad_oe),
		.hbr_pins_o    (hbr_pins),
		.core_reset_o  (core_reset)
	);

	task automatic abort_test(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp)
			abort_test($sformatf("FAIL @ %0t ns: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_gpio(input gpio_t got, input gpio_t exp, input string what);
		if (got !== exp)
			abort_test($sformatf("FAIL @ %0t ns: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic check_pins(input hbr_pins_t got, input hbr_pins_t exp, input string what);
		if (got !== exp)
			abort_test($sformatf("FAIL @ %0t ns: %s got %h expected %h", $time, what, got, exp));
	endtask

	// one-cycle write strobe, sampled on the second edge
	task automatic mmio_write(input addr_t addr, input word_t data);
		@(posedge clock_50mhz);
		mmio_wr    <= 1'b1;
		mmio_addr  <= addr;
		mmio_wdata <= data;
		@(posedge clock_50mhz);
		mmio_wr    <= 1'b0;
	endtask

	// read strobe, then wait for the valid pulse
	task automatic mmio_read(input addr_t addr, output word_t data);
		int wait_cnt;
		wait_cnt = 0;
		@(posedge clock_50mhz);
		mmio_rd   <= 1'b1;
		mmio_addr <= addr;
		@(posedge clock_50mhz);
		mmio_rd   <= 1'b0;
		@(negedge clock_50mhz);
		while (!mmio_rvalid)
		begin
			if (wait_cnt >= 4)
				abort_test($sformatf("no read valid for address %0d after 4 cycles", addr));
			else
			begin
				@(negedge clock_50mhz);
				wait_cnt++;
			end
		end
		data = mmio_rdata;
		// valid must show on the first cycle and last only one
		if (wait_cnt != 0)
			abort_test($sformatf("FAIL @ %0t ns: read valid %0d cycles late", $time, wait_cnt));
		else
		begin
			@(negedge clock_50mhz);
			if (mmio_rvalid)
				abort_test($sformatf("FAIL @ %0t ns: read valid longer than one cycle", $time));
		end
	endtask

	task automatic test_reset();
		int wait_cnt;
		int edges;
		word_t rval;
		wait_cnt = 0;
		@(negedge clock_50mhz);
		if (!core_reset)
			abort_test("core reset is low while the external reset is held");
		while (reset2a)
		begin
			if (wait_cnt >= 8)
				abort_test("external reset was never released");
			else
			begin
				@(negedge clock_50mhz);
				wait_cnt++;
			end
		end
		// write during the hold window, must be dropped
		mmio_write(REG_GPIO_DIR, 16'hffff);
		edges = 2;
		@(negedge clock_50mhz);
		while (core_reset)
		begin
			if (edges >= int'(RESET_HOLD_COUNT) + 1)
				abort_test("core reset still high after the hold count ran out");
			else
			begin
				@(posedge clock_50mhz);
				edges++;
				@(negedge clock_50mhz);
			end
		end
		mmio_read(REG_GPIO_DIR, rval);
		check_word(rval, 16'h0000, "gpio dir after write during reset");
		check_gpio(pad_oe, 16'h0000, "gpio_oe_o after reset");
		check_pins(hbr_pins, 8'h00, "hbr pins after reset");
	endtask

	task automatic test_regs();
		word_t wval;
		word_t rval;
		word_t duty_w [HBR_CHANNELS];
		wval = word_t'($urandom);
		mmio_write(REG_GPIO_OUT, wval);
		mmio_read(REG_GPIO_OUT, rval);
		check_word(rval, wval, "gpio out readback");
		wval = word_t'($urandom);
		mmio_write(REG_GPIO_DIR, wval);
		mmio_read(REG_GPIO_DIR, rval);
		check_word(rval, wval, "gpio dir readback");
		// 8-bit registers keep the low byte
		wval = word_t'($urandom);
		mmio_write(REG_HBR_CTRL, wval);
		mmio_read(REG_HBR_CTRL, rval);
		check_word(rval, wval & 16'h00ff, "hbr ctrl readback");
		for (int k = 0; k < HBR_CHANNELS; k++)
		begin
			duty_w[k] = word_t'($urandom);
			mmio_write(REG_HBR_DUTY0 + addr_t'(k), duty_w[k]);
		end
		for (int k = 0; k < HBR_CHANNELS; k++)
		begin
			mmio_read(REG_HBR_DUTY0 + addr_t'(k), rval);
			check_word(rval, duty_w[k] & 16'h00ff, $sformatf("duty %0d readback", k));
		end
		// upper half of the map is empty
		for (int a = 8; a < 16; a++)
		begin
			mmio_read(addr_t'(a), rval);
			check_word(rval, 16'h0000, $sformatf("unmapped address %0d", a));
		end
		mmio_write(REG_HBR_CTRL, 16'h0000);
	endtask

	task automatic test_gpio();
		gpio_t dir_v;
		gpio_t out_v;
		gpio_t ext_v;
		gpio_t pad_exp;
		word_t rval;
		for (int r = 0; r < 2; r++)
		begin
			dir_v = gpio_t'($urandom);
			out_v = gpio_t'($urandom);
			ext_v = gpio_t'($urandom);
			@(posedge clock_50mhz);
			ext_val <= ext_v;
			mmio_write(REG_GPIO_OUT, word_t'(out_v));
			mmio_write(REG_GPIO_DIR, word_t'(dir_v));
			@(negedge clock_50mhz);
			check_gpio(pad_oe, dir_v, "gpio_oe_o");
			check_gpio(pad_out, out_v, "gpio_pin_o");
			// two synchronizer stages
			repeat (2) @(posedge clock_50mhz);
			pad_exp = (out_v & dir_v) | (ext_v & ~dir_v);
			mmio_read(REG_GPIO_IN, rval);
			check_gpio(gpio_t'(rval), pad_exp, "gpio in readback");
		end
	endtask

	task automatic test_pwm();
		duty_t duty_v [HBR_CHANNELS];
		logic [3:0] dirs;
		int high_cnt [8];
		int act;
		int wait_cnt;
		dirs = 4'($urandom);
		// channel 0 at duty 0, the rest random
		for (int k = 0; k < HBR_CHANNELS; k++)
		begin
			duty_v[k] = (k == 0) ? 8'd0 : duty_t'($urandom);
			mmio_write(REG_HBR_DUTY0 + addr_t'(k), word_t'(duty_v[k]));
		end
		mmio_write(REG_HBR_CTRL, {8'h00, dirs, 3'b000, 1'b1});
		for (int p = 0; p < 8; p++)
			high_cnt[p] = 0;
		// pins are registered, one edge before the new settings show
		@(posedge clock_50mhz);
		repeat (256)
		begin
			@(negedge clock_50mhz);
			for (int p = 0; p < 8; p++)
				high_cnt[p] = high_cnt[p] + (hbr_pins[p] ? 1 : 0);
		end
		for (int k = 0; k < HBR_CHANNELS; k++)
		begin
			act = dirs[k] ? 2 * k + 1 : 2 * k;
			check_word(word_t'(high_cnt[act]), word_t'(duty_v[k]),
				$sformatf("high cycles on active pin of channel %0d", k));
			check_word(word_t'(high_cnt[act ^ 1]), 16'h0000,
				$sformatf("high cycles on idle pin of channel %0d", k));
		end
		// enable off, all pins low within 2 cycles
		mmio_write(REG_HBR_CTRL, {8'h00, dirs, 4'b0000});
		wait_cnt = 0;
		@(negedge clock_50mhz);
		while (hbr_pins != 8'h00)
		begin
			if (wait_cnt >= 2)
				abort_test("H-bridge pins still driven 2 cycles after disable");
			else
			begin
				@(negedge clock_50mhz);
				wait_cnt++;
			end
		end
		// a whole period, so every nonzero duty would have shown
		repeat (256)
		begin
			@(negedge clock_50mhz);
			check_pins(hbr_pins, 8'h00, "hbr pins while disabled");
		end
	endtask

	initial
	begin
		mmio_wr    = 1'b0;
		mmio_rd    = 1'b0;
		mmio_addr  = '0;
		mmio_wdata = '0;
		ext_val    = '0;
		void'($urandom(32'h7c28_cf1a));
		test_reset();
		test_regs();
		test_gpio();
		test_pwm();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
logic/board_pkg.sv
logic/reset_sanity.sv
logic/mmio_decode.sv
logic/gpio_port.sv
logic/hbr_pwm.sv
logic/board_top.sv
verif/tb_clock_gen.sv
verif/board_props.sv
verif/tb_board.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the board testbench with Verilator and run it
# exit status is nonzero when the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--timescale 1ns/10ps \
	--top-module tb_board \
	-f sources.f \
	-o sim_board \
	&& ./obj_dir/sim_board \
	|| { echo "simulation build or run failed"; exit 1; }
